// ==== list.f ====
verilog/dma_frontend_pkg.sv
verilog/dma_access_if.sv
verilog/dma_reg_decode.sv
verilog/dma_frontend_regs.sv
verilog/dma_read_response.sv
verilog/dma_transfer_tracker.sv
verilog/dma_frontend_top.sv
testbench/dma_frontend_assertions.sv
testbench/tb_dma_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the dma front end testbench with Verilator and run it
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_dma_frontend -Mdir obj_dir -o tb_dma_frontend
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dma_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
exit 0

// ==== testbench/tb_dma_frontend.sv ====
/*
 * dma front end testbench
 * register accesses with LFSR data, a register file model with ids,
 * and a process that checks every response pulse
 */
module tb_dma_frontend;

    localparam int ResetCycles   = 16;
    localparam int AccessCycles  = 2;
    localparam int NumAccesses   = 50;
    localparam int NumTransfers  = 3;
    localparam int MaxBeats      = 68;
    localparam int TimeoutCycles = ResetCycles + NumAccesses * AccessCycles
                                 + NumTransfers * (MaxBeats + 2 * AccessCycles) + 50;

    logic        clk_i;
    logic        rst_ni;
    logic        ctrl_req_i;
    logic        ctrl_type_i;
    logic [3:0]  ctrl_be_i;
    logic [31:0] ctrl_add_i;
    logic [31:0] ctrl_data_i;
    logic        ctrl_gnt_o;
    logic        ctrl_valid_o;
    logic [31:0] ctrl_data_o;
    logic [0:0]  stream_sel_i;

    // register file and id model
    logic [31:0] m_src, m_dst, m_num;
    logic [2:0]  m_conf;
    logic [27:0] m_next [2];
    logic [27:0] m_done [2];
    logic [27:0] m_id;
    logic [0:0]  m_stream;
    int          m_busy_left;
    logic        pend_launch;
    logic [0:0]  pend_stream;

    logic [31:0] expect_q [$];
    logic [31:0] last_rdata;
    logic [31:0] first_id;
    logic [0:0]  sel;
    logic [15:0] lfsr_q;
    int          cycles;
    int          wait_cycles;

    dma_frontend_top #(.NumStreams(2)) UUT (
        .clk_i, .rst_ni, .ctrl_req_i, .ctrl_type_i, .ctrl_be_i, .ctrl_add_i,
        .ctrl_data_i, .ctrl_gnt_o, .ctrl_valid_o, .ctrl_data_o, .stream_sel_i
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // taps 16, 14, 13, 11
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] be);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    // expected response word, taken from the model state before the grant edge
    function automatic logic [31:0] expected_word(input logic rd, input logic [7:0] addr,
                                                  input logic [0:0] s);
        logic [31:0] w;
        w = 32'h0;
        if (rd) begin
            case (addr)
                8'h00: w = m_src;
                8'h08: w = m_dst;
                8'h10: w = m_num;
                8'h18: w = {15'b0, m_busy_left != 0, 13'b0, m_conf};
                8'h20: if (m_num != 0) w = {3'b0, s, m_next[s]};
                8'h28: w = {4'b0, m_done[0]};
                8'h30: w = {4'b0, m_done[1]};
                default: w = 32'h0;
            endcase
        end
        return w;
    endfunction

    // only a counted next-id read meets back-pressure, and only while busy
    function automatic logic grant_expected(input logic rd, input logic [7:0] addr);
        return !(rd && addr == 8'h20 && m_num != 0 && m_busy_left != 0);
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                                $time, name, got, exp));
    endtask

    // one access, from request until its response pulse
    task automatic bus_access(input logic rd, input logic [7:0] addr, input logic [3:0] be,
                              input logic [31:0] data, input logic [0:0] s);
        ctrl_req_i   = 1'b1;
        ctrl_type_i  = rd;
        ctrl_add_i   = {24'h0, addr};
        ctrl_be_i    = be;
        ctrl_data_i  = data;
        stream_sel_i = s;
        wait_cycles  = 0;
        @(negedge clk_i);
        check_word("ctrl_gnt_o", 32'(ctrl_gnt_o), 32'(grant_expected(rd, addr)));
        while (!ctrl_gnt_o) begin
            wait_cycles++;
            @(negedge clk_i);
            check_word("ctrl_gnt_o", 32'(ctrl_gnt_o), 32'(grant_expected(rd, addr)));
        end
        expect_q.push_back(expected_word(rd, addr, s));
        if (!rd) begin
            case (addr)
                8'h00: m_src = merge_bytes(m_src, data, be);
                8'h08: m_dst = merge_bytes(m_dst, data, be);
                8'h10: m_num = merge_bytes(m_num, data, be);
                8'h18: m_conf = data[2:0];
                default: ;
            endcase
        end else if (addr == 8'h20 && m_num != 0) begin
            pend_launch = 1'b1;
            pend_stream = s;
        end
        @(posedge clk_i);
        #10 ctrl_req_i = 1'b0;
        @(negedge clk_i);
        assert (ctrl_valid_o) else fail_run("no response pulse one cycle after the grant");
        last_rdata = ctrl_data_o;
        @(posedge clk_i);
        #10;
    endtask

    task automatic wait_idle();
        do begin
            bus_access(1'b1, 8'h18, 4'hf, 32'h0, sel);
        end while (last_rdata[16]);
    endtask

    // tracker model, advanced at each clock edge
    always @(posedge clk_i) begin
        if (pend_launch) begin
            m_busy_left = (m_num == 0) ? 1 : int'((64'(m_num) + 3) / 4);
            m_id        = m_next[pend_stream];
            m_stream    = pend_stream;
            m_next[pend_stream] = m_next[pend_stream] + 1;
            pend_launch = 1'b0;
        end else if (m_busy_left != 0) begin
            m_busy_left--;
            if (m_busy_left == 0) m_done[m_stream] = m_id;
        end
    end

    // every response pulse against the word queued at its grant
    always @(negedge clk_i) begin
        if (rst_ni && ctrl_valid_o) begin
            assert (expect_q.size() != 0) else fail_run("response pulse without a granted access");
            if (expect_q.size() != 0) check_word("ctrl_data_o", ctrl_data_o, expect_q.pop_front());
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > TimeoutCycles) begin
            $display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    initial begin
        lfsr_q = 16'd48291;
        {ctrl_req_i, ctrl_type_i, ctrl_be_i, ctrl_add_i, ctrl_data_i} = '0;
        stream_sel_i = '0;
        {m_src, m_dst, m_num} = '0;
        m_conf = 3'b101;
        m_next = '{28'd1, 28'd1};
        m_done = '{28'd0, 28'd0};
        {m_id, m_stream, m_busy_left, pend_launch, pend_stream} = '0;
        {cycles, wait_cycles, sel} = '0;
        rst_ni = 1'b0;
        repeat (ResetCycles) @(posedge clk_i);
        #10 rst_ni = 1'b1;
        @(posedge clk_i);
        #10;

        // values after reset
        bus_access(1'b1, 8'h18, 4'hf, 32'h0, 1'b0);
        check_word("status after reset", last_rdata, 32'h5);
        bus_access(1'b1, 8'h00, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h08, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h10, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h28, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h30, 4'hf, 32'h0, 1'b0);

        // byte-enabled writes with read back
        repeat (3) begin
            for (int r = 0; r < 3; r++) begin
                bus_access(1'b0, 8'(8 * r), 4'(lfsr_bits(4)), lfsr_bits(32), 1'b0);
            end
            for (int r = 0; r < 3; r++) begin
                bus_access(1'b1, 8'(8 * r), 4'hf, 32'h0, 1'b0);
            end
        end

        // configuration, invalid addresses, unused done-id slot
        bus_access(1'b0, 8'h18, 4'hf, 32'hffff_fffa, 1'b0);
        bus_access(1'b1, 8'h18, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h40, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h38, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h04, 4'hf, 32'h0, 1'b0);

        // zero count launches nothing
        bus_access(1'b0, 8'h10, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h20, 4'hf, 32'h0, 1'b0);
        bus_access(1'b1, 8'h20, 4'hf, 32'h0, 1'b1);
        bus_access(1'b1, 8'h18, 4'hf, 32'h0, 1'b0);

        // single launch on a random stream
        sel = lfsr_bits(1);
        bus_access(1'b0, 8'h10, 4'hf, lfsr_bits(8) + 32'd16, 1'b0);
        bus_access(1'b1, 8'h20, 4'hf, 32'h0, sel);
        first_id = last_rdata;
        check_word("launch stream index", {28'h0, first_id[31:28]}, {31'h0, sel});
        check_word("first launch id", {4'h0, first_id[27:0]}, 32'd1);
        wait_idle();
        bus_access(1'b1, 8'(8'h28 + 8 * sel), 4'hf, 32'h0, 1'b0);
        check_word("done id after launch", last_rdata, {4'h0, first_id[27:0]});

        // second launch stalls while the first one is busy
        bus_access(1'b0, 8'h10, 4'hf, lfsr_bits(8) + 32'd16, 1'b0);
        bus_access(1'b1, 8'h20, 4'hf, 32'h0, sel);
        check_word("next id went up", {4'h0, last_rdata[27:0]}, {4'h0, first_id[27:0]} + 1);
        first_id = last_rdata;
        bus_access(1'b1, 8'h20, 4'hf, 32'h0, sel);
        assert (wait_cycles > 0) else fail_run("second launch was granted while the tracker was busy");
        check_word("id after stall", {4'h0, last_rdata[27:0]}, {4'h0, first_id[27:0]} + 1);
        first_id = last_rdata;
        wait_idle();
        bus_access(1'b1, 8'(8'h28 + 8 * sel), 4'hf, 32'h0, 1'b0);
        check_word("done id after stall", last_rdata, {4'h0, first_id[27:0]});

        assert (expect_q.size() == 0) else fail_run("responses missing at the end of the run");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== testbench/dma_frontend_assertions.sv ====
/*
 * dma front end protocol checks
 * bound into the register store and the read response
 */
module dma_frontend_assertions #(
    parameter bit CheckStall = 1'b0
) (
    input logic clk_i,
    input logic rst_ni,
    input logic req_i,
    input logic gnt_i,
    input logic launch_i,
    input logic ready_i
);

    // a granted launch always leaves the tracker busy in the next cycle
    launch_starts_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_i && gnt_i && launch_i) |=> !ready_i)
        else $error("tracker stayed idle after a launch");

    if (CheckStall) begin : gen_stall
        // master keeps a stalled request up until the grant
        stall_holds_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
            (req_i && !gnt_i) |=> req_i)
            else $error("request dropped while it was stalled");
    end

endmodule

bind dma_frontend_regs dma_frontend_assertions #(.CheckStall(1'b1)) i_regs_checks (
    .clk_i, .rst_ni, .req_i(acc.req), .gnt_i(acc.gnt), .launch_i(launch_o),
    .ready_i(tracker_ready_i)
);

bind dma_read_response dma_frontend_assertions #(.CheckStall(1'b0)) i_result_checks (
    .clk_i, .rst_ni, .req_i(acc.req), .gnt_i(acc.gnt),
    .launch_i(!acc.write && (acc.sel == dma_frontend_pkg::REG_NEXT_ID)
              && (descr_i.num_bytes != '0)),
    .ready_i(~busy_i)
);

// ==== verilog/dma_frontend_top.sv ====
/*
 * dma programming front end
 * control port decode, register store, read response and transfer tracker
 */
module dma_frontend_top #(
    parameter int unsigned NumStreams = 2,
    localparam int unsigned StreamIdxWidth = (NumStreams > 1) ? $clog2(NumStreams) : 1
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      ctrl_req_i,
    input  logic                      ctrl_type_i,
    input  logic [3:0]                ctrl_be_i,
    input  logic [31:0]               ctrl_add_i,
    input  logic [31:0]               ctrl_data_i,
    output logic                      ctrl_gnt_o,
    output logic                      ctrl_valid_o,
    output logic [31:0]               ctrl_data_o,
    input  logic [StreamIdxWidth-1:0] stream_sel_i
);
    import dma_frontend_pkg::*;

    transf_descr_t                      descr;
    logic                               launch, tracker_ready, busy;
    logic [NumStreams-1:0][IdWidth-1:0] next_id, done_id;

    dma_access_if #(.NumStreams(NumStreams)) acc ();

    assign ctrl_gnt_o = acc.gnt;

    dma_reg_decode #(.NumStreams(NumStreams)) i_decode (
        .ctrl_req_i, .ctrl_type_i, .ctrl_be_i, .ctrl_add_i, .ctrl_data_i, .acc(acc)
    );

    dma_frontend_regs #(.NumStreams(NumStreams)) i_regs (
        .clk_i, .rst_ni, .acc(acc), .tracker_ready_i(tracker_ready),
        .launch_o(launch), .descr_o(descr)
    );

    dma_read_response #(.NumStreams(NumStreams)) i_result (
        .clk_i, .rst_ni, .acc(acc), .descr_i(descr), .busy_i(busy), .next_id_i(next_id),
        .done_id_i(done_id), .stream_sel_i, .ctrl_valid_o, .ctrl_data_o
    );

    dma_transfer_tracker #(.NumStreams(NumStreams)) i_tracker (
        .clk_i, .rst_ni, .launch_i(launch), .descr_i(descr), .stream_sel_i,
        .tracker_ready_o(tracker_ready), .busy_o(busy), .next_id_o(next_id),
        .done_id_o(done_id)
    );

endmodule

// ==== verilog/dma_transfer_tracker.sv ====
/*
 * dma transfer tracker
 * stands in for the data mover: one descriptor at a time, busy for one
 * cycle per started word, per-stream next and done ids
 */
module dma_transfer_tracker #(
    parameter int unsigned NumStreams = 2,
    localparam int unsigned StreamIdxWidth = (NumStreams > 1) ? $clog2(NumStreams) : 1
) (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,
    input  logic                                                launch_i,
    input  dma_frontend_pkg::transf_descr_t                     descr_i,
    input  logic [StreamIdxWidth-1:0]                           stream_sel_i,
    output logic                                                tracker_ready_o,
    output logic                                                busy_o,
    output logic [NumStreams-1:0][dma_frontend_pkg::IdWidth-1:0] next_id_o,
    output logic [NumStreams-1:0][dma_frontend_pkg::IdWidth-1:0] done_id_o
);
    import dma_frontend_pkg::*;

    logic [NumStreams-1:0][IdWidth-1:0] next_id_q, done_id_q;
    logic [StreamIdxWidth-1:0]          stream_q;
    logic [IdWidth-1:0]                 id_q;
    logic [30:0]                        beats, beats_q;
    logic                               busy_q;

    // ceil(num_bytes / 4), at least one
    assign beats = (descr_i.num_bytes == '0) ? 31'd1
                 : 31'(descr_i.num_bytes[31:2]) + 31'(|descr_i.num_bytes[1:0]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            beats_q  <= '0;
            stream_q <= '0;
            id_q     <= '0;
            for (int s = 0; s < NumStreams; s++) begin
                next_id_q[s] <= IdWidth'(1);
                done_id_q[s] <= '0;
            end
        end else if (launch_i) begin
            busy_q                  <= 1'b1;
            beats_q                 <= beats;
            stream_q                <= stream_sel_i;
            id_q                    <= next_id_q[stream_sel_i];
            next_id_q[stream_sel_i] <= next_id_q[stream_sel_i] + 1'b1;
        end else if (busy_q) begin
            // last beat retires the transfer
            if (beats_q == 31'd1) begin
                busy_q              <= 1'b0;
                done_id_q[stream_q] <= id_q;
            end
            beats_q <= beats_q - 1'b1;
        end
    end

    assign tracker_ready_o = ~busy_q;
    assign busy_o          = busy_q;
    assign next_id_o       = next_id_q;
    assign done_id_o       = done_id_q;

endmodule

// ==== verilog/dma_read_response.sv ====
/*
 * dma read response
 * forms the read word and returns it one cycle after the grant
 */
module dma_read_response #(
    parameter int unsigned NumStreams = 2,
    localparam int unsigned StreamIdxWidth = (NumStreams > 1) ? $clog2(NumStreams) : 1
) (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,
    dma_access_if.result                                       acc,
    input  dma_frontend_pkg::transf_descr_t                    descr_i,
    input  logic                                               busy_i,
    input  logic [NumStreams-1:0][dma_frontend_pkg::IdWidth-1:0] next_id_i,
    input  logic [NumStreams-1:0][dma_frontend_pkg::IdWidth-1:0] done_id_i,
    input  logic [StreamIdxWidth-1:0]                          stream_sel_i,
    output logic                                               ctrl_valid_o,
    output logic [31:0]                                        ctrl_data_o
);
    import dma_frontend_pkg::*;

    logic [31:0] rdata_d, rdata_q;
    logic        valid_q;
    logic        fire;
    logic [2:0]  conf;

    assign fire = acc.req & acc.gnt;
    assign conf = {descr_i.serialize, descr_i.deburst, descr_i.decouple};

    always_comb begin
        rdata_d = '0;
        // writes answer with zero
        if (!acc.write) begin
            case (acc.sel)
                REG_SRC:  rdata_d = descr_i.src_addr;
                REG_DST:  rdata_d = descr_i.dst_addr;
                REG_NUM:  rdata_d = descr_i.num_bytes;
                REG_CONF: rdata_d = {15'b0, busy_i, 13'b0, conf};
                REG_NEXT_ID: begin
                    if (descr_i.num_bytes != '0) begin
                        rdata_d = {4'(stream_sel_i), next_id_i[stream_sel_i]};
                    end
                end
                REG_DONE_ID: rdata_d = {4'b0, done_id_i[acc.stream]};
                default: rdata_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fire;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fire) begin
            rdata_q <= rdata_d;
        end
    end

    assign ctrl_valid_o = valid_q;
    assign ctrl_data_o  = rdata_q;

endmodule

// ==== verilog/dma_frontend_regs.sv ====
/*
 * dma frontend register store
 * byte-enabled descriptor writes, configuration bits, access grant
 * and transfer launch on a next-id read
 */
module dma_frontend_regs #(
    parameter int unsigned NumStreams = 2
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    dma_access_if.execute                  acc,
    input  logic                           tracker_ready_i,
    output logic                           launch_o,
    output dma_frontend_pkg::transf_descr_t descr_o
);
    import dma_frontend_pkg::*;

    // stream index field of the next-id word is four bits wide
    if (NumStreams < 1 || NumStreams > 16) begin : gen_stream_range
        $error("NumStreams must be between 1 and 16");
    end

    dma_data_store_t store_d, store_q;
    logic [2:0]      conf_d, conf_q;
    logic            gnt;
    logic            id_read;
    logic            count_set;
    logic            wr_fire;
    logic [1:0]      word_idx;

    assign count_set = (store_q.words[2] != '0);
    assign id_read   = acc.req & ~acc.write & (acc.sel == REG_NEXT_ID);

    // hold off a launch until the tracker is idle
    assign gnt      = acc.req & ~(id_read & count_set & ~tracker_ready_i);
    assign acc.gnt  = gnt;
    assign launch_o = id_read & count_set & gnt;

    assign wr_fire  = acc.req & gnt & acc.write;
    assign word_idx = acc.sel[1:0];

    always_comb begin
        store_d = store_q;
        conf_d  = conf_q;
        if (wr_fire) begin
            case (acc.sel)
                REG_SRC, REG_DST, REG_NUM: begin
                    for (int b = 0; b < 4; b++) begin
                        if (acc.be[b]) begin
                            store_d.bytes[word_idx][b] = acc.wdata[8*b +: 8];
                        end
                    end
                end
                REG_CONF: conf_d = acc.wdata[2:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            store_q <= '0;
            conf_q  <= ConfResetValue;
        end else begin
            store_q <= store_d;
            conf_q  <= conf_d;
        end
    end

    assign descr_o.src_addr  = store_q.words[0];
    assign descr_o.dst_addr  = store_q.words[1];
    assign descr_o.num_bytes = store_q.words[2];
    assign descr_o.decouple  = conf_q[0];
    assign descr_o.deburst   = conf_q[1];
    assign descr_o.serialize = conf_q[2];

endmodule

// ==== verilog/dma_reg_decode.sv ====
/*
 * dma register decode
 * maps a raw control request onto a register select and stream index
 */
module dma_reg_decode #(
    parameter int unsigned NumStreams = 2,
    localparam int unsigned StreamIdxWidth = (NumStreams > 1) ? $clog2(NumStreams) : 1
) (
    input  logic               ctrl_req_i,
    input  logic               ctrl_type_i,
    input  logic [3:0]         ctrl_be_i,
    input  logic [31:0]        ctrl_add_i,
    input  logic [31:0]        ctrl_data_i,
    dma_access_if.decode       acc
);
    import dma_frontend_pkg::*;

    // first address past the last done-id slot
    localparam int unsigned DoneIdLimit = DoneIdBase + NumStreams * DoneIdStride;

    logic [7:0] reg_addr;
    logic [7:0] done_off;

    // only the low byte selects a register
    assign reg_addr = ctrl_add_i[7:0];
    assign done_off = reg_addr - DoneIdBase;

    assign acc.req   = ctrl_req_i;
    assign acc.write = ~ctrl_type_i;
    assign acc.be    = ctrl_be_i;
    assign acc.wdata = ctrl_data_i;

    always_comb begin
        acc.stream = done_off[3 +: StreamIdxWidth];
        case (reg_addr)
            SrcOffset:    acc.sel = REG_SRC;
            DstOffset:    acc.sel = REG_DST;
            NumOffset:    acc.sel = REG_NUM;
            ConfOffset:   acc.sel = REG_CONF;
            NextIdOffset: acc.sel = REG_NEXT_ID;
            default: begin
                // done-id slots exist only for configured streams
                if (reg_addr >= DoneIdBase && 32'(reg_addr) < DoneIdLimit) begin
                    acc.sel = REG_DONE_ID;
                end else begin
                    acc.sel = REG_INVALID;
                end
            end
        endcase
    end

endmodule

// ==== verilog/dma_access_if.sv ====
/*
 * dma control access
 * one decoded register access, shared by decode, execute and result
 */
interface dma_access_if #(
    parameter int unsigned NumStreams = 2
);
    import dma_frontend_pkg::*;

    localparam int unsigned StreamIdxWidth = (NumStreams > 1) ? $clog2(NumStreams) : 1;

    logic                      req;
    logic                      write;
    logic [3:0]                be;
    logic [31:0]               wdata;
    reg_sel_e                  sel;
    logic [StreamIdxWidth-1:0] stream;
    logic                      gnt;

    modport decode (output req, write, be, wdata, sel, stream);

    modport execute (input req, write, be, wdata, sel, output gnt);

    modport result (input req, write, sel, stream, gnt);

endinterface

// ==== verilog/dma_frontend_pkg.sv ====
/*
 * dma frontend package
 * transfer descriptor, register store views, register map and id width
 */
package dma_frontend_pkg;

    // width of a transfer id
    localparam int unsigned IdWidth = 28;

    // register map, low address byte
    localparam logic [7:0] SrcOffset    = 8'h00;
    localparam logic [7:0] DstOffset    = 8'h08;
    localparam logic [7:0] NumOffset    = 8'h10;
    localparam logic [7:0] ConfOffset   = 8'h18;
    localparam logic [7:0] NextIdOffset = 8'h20;
    localparam logic [7:0] DoneIdBase   = 8'h28;
    localparam int unsigned DoneIdStride = 8;

    // serialize, deburst, decouple
    localparam logic [2:0] ConfResetValue = 3'b101;

    typedef struct packed {
        logic [31:0] num_bytes;
        logic [31:0] dst_addr;
        logic [31:0] src_addr;
        logic        decouple;
        logic        deburst;
        logic        serialize;
    } transf_descr_t;

    // word 0 source, word 1 destination, word 2 byte count
    typedef union packed {
        logic [2:0][31:0]     words;
        logic [2:0][3:0][7:0] bytes;
    } dma_data_store_t;

    // first three values double as the store word index
    typedef enum logic [2:0] {
        REG_SRC     = 3'd0,
        REG_DST     = 3'd1,
        REG_NUM     = 3'd2,
        REG_CONF    = 3'd3,
        REG_NEXT_ID = 3'd4,
        REG_DONE_ID = 3'd5,
        REG_INVALID = 3'd6
    } reg_sel_e;

endpackage
